/* src.f */
src/aud_pkg.sv
src/aud_recorder.sv
src/aud_player.sv
src/sample_ram.sv
src/aud_ctrl.sv
src/aud_core_top.sv
sim/tb_aud_core.sv

/* run_sim.sh */
#!/bin/sh
# build the audio core testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_aud_core -o tb_aud_core \
    && ./obj_dir/tb_aud_core > sim.log 2>&1 \
    || { echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "STATUS: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "no result in log"; exit 1; }
echo "simulation passed"
exit 0

/* sim/tb_aud_core.sv */
`timescale 1ns/1ps

module tb_aud_core
    import aud_pkg::*;
();

    localparam int DEPTH = 64;
    localparam int AW    = $clog2(DEPTH);

    localparam aud_cmd_t CMD_REC   = '{start_rec: 1'b1, start_play: 1'b0, pause: 1'b0, stop: 1'b0};
    localparam aud_cmd_t CMD_PLAY  = '{start_rec: 1'b0, start_play: 1'b1, pause: 1'b0, stop: 1'b0};
    localparam aud_cmd_t CMD_PAUSE = '{start_rec: 1'b0, start_play: 1'b0, pause: 1'b1, stop: 1'b0};
    localparam aud_cmd_t CMD_STOP  = '{start_rec: 1'b0, start_play: 1'b0, pause: 1'b0, stop: 1'b1};

    logic        i_bclk = 1'b0;
    logic        i_rst_n;
    logic        i_daclrck;
    logic        i_adcdat;
    aud_cmd_t    i_cmd;
    logic        o_dacdat;
    aud_mode_e   o_mode;
    logic [AW:0] o_rec_count;
    logic        o_play_done;

    sample_t exp_q[$];      // words the core should hold, in order
    string   cur_test;
    int      test_errs;
    int      errors;
    int      tests_run;
    int      tests_failed;
    int      done_pulses = 0;

    always #50 i_bclk = ~i_bclk;

    aud_core_top #(
        .P_DEPTH(DEPTH)
    ) aud_core_top_i (
        .i_bclk(i_bclk),
        .i_rst_n(i_rst_n),
        .i_daclrck(i_daclrck),
        .i_adcdat(i_adcdat),
        .i_cmd(i_cmd),
        .o_dacdat(o_dacdat),
        .o_mode(o_mode),
        .o_rec_count(o_rec_count),
        .o_play_done(o_play_done)
    );

    always @(negedge i_bclk) begin
        if (o_play_done === 1'b1) begin
            done_pulses++;
        end
    end

    // first of the 17 slot bits is the I2S delay bit
    function automatic sample_t expected_sample(input logic [REC_BITS-1:0] bits);
        return sample_t'(bits[SAMPLE_W-1:0]);
    endfunction

    task automatic next_cycle();
        @(posedge i_bclk);
        #1;
    endtask

    task automatic report_mismatch(input string what, input logic [15:0] exp_v,
                                   input logic [15:0] act_v);
        $display("mismatch %s %s: expected %h actual %h", cur_test, what, exp_v, act_v);
        test_errs++;
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("%s: %s", cur_test, what);
        test_errs++;
        errors++;
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errs == 0) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, test_errs);
        end
    endtask

    task automatic apply_reset();
        i_rst_n   = 1'b0;
        i_daclrck = 1'b1;
        i_adcdat  = 1'b0;
        i_cmd     = '0;
        repeat (4) begin
            next_cycle();
        end
        i_rst_n = 1'b1;
        next_cycle();
    endtask

    task automatic send_cmd(input aud_cmd_t cmd);
        next_cycle();
        i_cmd = cmd;
        next_cycle();
        i_cmd = '0;
        repeat (3) begin    // lets the recorder rearm before the next frame
            next_cycle();
        end
    endtask

    // one codec frame, 24 cycles per slot; also collects both DAC words
    task automatic run_frame(output logic [REC_BITS-1:0] bits,
                             output sample_t left_w, output sample_t right_w);
        int k;
        bits    = {1'($urandom), 16'($urandom)};
        left_w  = '0;
        right_w = '0;
        next_cycle();
        i_daclrck = 1'b0;
        i_adcdat  = bits[REC_BITS-1];
        for (k = 1; k < 24; k++) begin
            next_cycle();
            i_adcdat = (k <= 16) ? bits[16-k] : 1'b0;
            if (k >= 2 && k <= 17) begin
                left_w[17-k] = o_dacdat;    // msb registered two edges in
            end
        end
        next_cycle();
        i_daclrck = 1'b1;
        for (k = 1; k < 24; k++) begin
            next_cycle();
            if (k >= 2 && k <= 17) begin
                right_w[17-k] = o_dacdat;
            end
        end
    endtask

    task automatic record_frames(input int n, input bit keep);
        logic [REC_BITS-1:0] bits;
        sample_t             l_w;
        sample_t             r_w;
        int                  i;
        for (i = 0; i < n; i++) begin
            run_frame(bits, l_w, r_w);
            if (keep && exp_q.size() < DEPTH) begin
                exp_q.push_back(expected_sample(bits));
            end
        end
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (o_mode != MODE_IDLE && n < limit) begin
            next_cycle();
            n++;
        end
        if (o_mode != MODE_IDLE) begin
            report_failure("mode did not return to idle in time");
        end
    endtask

    // plays everything stored and compares each frame against exp_q
    task automatic play_and_check();
        logic [REC_BITS-1:0] bits;
        sample_t             l_w;
        sample_t             r_w;
        int                  nfr;
        int                  pulses0;
        nfr     = 0;
        pulses0 = done_pulses;
        send_cmd(CMD_PLAY);
        if (o_mode !== MODE_PLAY) begin
            report_mismatch("mode", 16'(MODE_PLAY), 16'(o_mode));
        end
        while (o_mode == MODE_PLAY && nfr < exp_q.size() + 2) begin
            run_frame(bits, l_w, r_w);
            if (nfr < exp_q.size()) begin
                if (l_w !== exp_q[nfr]) begin
                    report_mismatch($sformatf("left word %0d", nfr), exp_q[nfr], l_w);
                end
                if (r_w !== exp_q[nfr]) begin
                    report_mismatch($sformatf("right word %0d", nfr), exp_q[nfr], r_w);
                end
            end
            nfr++;
        end
        if (o_mode == MODE_PLAY) begin
            report_failure("timed out waiting for the end of playback");
        end
        if (nfr != exp_q.size()) begin
            report_mismatch("played frames", 16'(exp_q.size()), 16'(nfr));
        end
        if (done_pulses - pulses0 != 1) begin
            report_mismatch("play_done pulses", 16'd1, 16'(done_pulses - pulses0));
        end
    endtask

    initial begin
        logic [REC_BITS-1:0] bits;
        sample_t             l_w;
        sample_t             r_w;
        int                  pulses0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(32'hc23de547));
        apply_reset();

        start_test("reset");
        if (o_mode !== MODE_IDLE) begin
            report_mismatch("mode", 16'(MODE_IDLE), 16'(o_mode));
        end
        if (o_rec_count !== '0) begin
            report_mismatch("sample count", 16'd0, 16'(o_rec_count));
        end
        if (o_dacdat !== 1'b0) begin
            report_mismatch("dac data", 16'd0, 16'(o_dacdat));
        end
        if (o_play_done !== 1'b0) begin
            report_mismatch("play_done", 16'd0, 16'(o_play_done));
        end
        finish_test();

        start_test("record");
        exp_q.delete();
        send_cmd(CMD_REC);
        record_frames(8, 1'b1);
        send_cmd(CMD_STOP);
        wait_idle(10);
        if (o_rec_count !== (AW+1)'(8)) begin
            report_mismatch("sample count", 16'd8, 16'(o_rec_count));
        end
        finish_test();

        start_test("playback");
        play_and_check();
        finish_test();

        start_test("record_pause");
        exp_q.delete();
        send_cmd(CMD_REC);
        record_frames(3, 1'b1);
        send_cmd(CMD_PAUSE);
        if (o_mode !== MODE_PAUSE) begin
            report_mismatch("mode", 16'(MODE_PAUSE), 16'(o_mode));
        end
        record_frames(4, 1'b0);     // dropped while paused
        send_cmd(CMD_REC);
        record_frames(3, 1'b1);
        send_cmd(CMD_STOP);
        wait_idle(10);
        if (o_rec_count !== (AW+1)'(6)) begin
            report_mismatch("sample count", 16'd6, 16'(o_rec_count));
        end
        play_and_check();
        finish_test();

        start_test("full_memory");
        exp_q.delete();
        send_cmd(CMD_REC);
        record_frames(DEPTH + 3, 1'b1);
        wait_idle(10);
        if (o_rec_count !== (AW+1)'(DEPTH)) begin
            report_mismatch("sample count", 16'(DEPTH), 16'(o_rec_count));
        end
        play_and_check();
        finish_test();

        start_test("empty_play");
        apply_reset();
        pulses0 = done_pulses;
        send_cmd(CMD_PLAY);
        if (done_pulses - pulses0 != 1) begin
            report_mismatch("play_done pulses", 16'd1, 16'(done_pulses - pulses0));
        end
        if (o_mode !== MODE_IDLE) begin
            report_mismatch("mode", 16'(MODE_IDLE), 16'(o_mode));
        end
        run_frame(bits, l_w, r_w);
        if (l_w !== '0) begin
            report_mismatch("left word", 16'd0, l_w);
        end
        if (r_w !== '0) begin
            report_mismatch("right word", 16'd0, r_w);
        end
        finish_test();

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* src/aud_core_top.sv */
`timescale 1ns/1ps

module aud_core_top
    import aud_pkg::*;
#(
    parameter int P_DEPTH = 64,
    localparam int AW = $clog2(P_DEPTH)
) (
    input  logic        i_bclk,
    input  logic        i_rst_n,
    input  logic        i_daclrck,
    input  logic        i_adcdat,
    input  aud_cmd_t    i_cmd,
    output logic        o_dacdat,
    output aud_mode_e   o_mode,
    output logic [AW:0] o_rec_count,
    output logic        o_play_done
);

    logic          rec_start;
    logic          rec_pause;
    logic          rec_stop;
    logic          rec_full;
    logic          play_en;
    logic          frame_done;
    ram_wr_t       wr;
    logic [AW:0]   wr_addr;
    logic [AW-1:0] rd_addr;
    sample_t       rd_data;
    sample_t       play_sample;

    aud_ctrl #(
        .P_DEPTH(P_DEPTH)
    ) aud_ctrl_i (
        .i_bclk(i_bclk),
        .i_rst_n(i_rst_n),
        .i_cmd(i_cmd),
        .i_rec_count(o_rec_count),
        .i_rec_full(rec_full),
        .i_frame_done(frame_done),
        .i_rd_data(rd_data),
        .o_rec_start(rec_start),
        .o_rec_pause(rec_pause),
        .o_rec_stop(rec_stop),
        .o_play_en(play_en),
        .o_play_done(o_play_done),
        .o_rd_addr(rd_addr),
        .o_sample(play_sample),
        .o_mode(o_mode)
    );

    aud_recorder #(
        .P_DEPTH(P_DEPTH)
    ) aud_recorder_i (
        .i_bclk(i_bclk),
        .i_rst_n(i_rst_n),
        .i_daclrck(i_daclrck),
        .i_adcdat(i_adcdat),
        .i_start(rec_start),
        .i_pause(rec_pause),
        .i_stop(rec_stop),
        .o_wr(wr),
        .o_wr_addr(wr_addr),
        .o_count(o_rec_count),
        .o_full(rec_full)
    );

    sample_ram #(
        .P_DEPTH(P_DEPTH)
    ) sample_ram_i (
        .i_bclk(i_bclk),
        .i_wr(wr),
        .i_wr_addr(wr_addr),
        .i_rd_addr(rd_addr),
        .o_rd_data(rd_data)
    );

    aud_player aud_player_i (
        .i_bclk(i_bclk),
        .i_rst_n(i_rst_n),
        .i_daclrck(i_daclrck),
        .i_en(play_en),
        .i_sample(play_sample),
        .o_dacdat(o_dacdat),
        .o_frame_done(frame_done)
    );

endmodule

/* src/aud_ctrl.sv */
`timescale 1ns/1ps

module aud_ctrl
    import aud_pkg::*;
#(
    parameter int P_DEPTH = 64,
    localparam int AW = $clog2(P_DEPTH)
) (
    input  logic          i_bclk,
    input  logic          i_rst_n,
    input  aud_cmd_t      i_cmd,
    input  logic [AW:0]   i_rec_count,
    input  logic          i_rec_full,
    input  logic          i_frame_done,
    input  sample_t       i_rd_data,
    output logic          o_rec_start,
    output logic          o_rec_pause,
    output logic          o_rec_stop,
    output logic          o_play_en,
    output logic          o_play_done,
    output logic [AW-1:0] o_rd_addr,
    output sample_t       o_sample,
    output aud_mode_e     o_mode
);

    aud_mode_e     mode_r;
    logic          from_play_r;     // which side a pause belongs to
    logic          pause_req_r;
    logic          en_r;
    logic          last_r;          // held sample is the final one
    logic [1:0]    wait_cnt_r;
    logic [AW-1:0] rd_addr_r;
    logic [AW:0]   cnt_last;
    logic          load;
    sample_t       held_r;

    assign cnt_last  = i_rec_count - 1'b1;
    assign load      = (mode_r == MODE_PLAY) &&
                       ((wait_cnt_r == 2'd1) || (i_frame_done && en_r && !last_r));
    assign o_play_en = en_r;
    assign o_rd_addr = rd_addr_r;
    assign o_sample  = held_r;
    assign o_mode    = mode_r;

    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mode_r      <= MODE_IDLE;
            from_play_r <= 1'b0;
            pause_req_r <= 1'b0;
            en_r        <= 1'b0;
            last_r      <= 1'b0;
            wait_cnt_r  <= '0;
            rd_addr_r   <= '0;
            o_rec_start <= 1'b0;
            o_rec_pause <= 1'b0;
            o_rec_stop  <= 1'b0;
            o_play_done <= 1'b0;
        end else begin
            o_rec_start <= 1'b0;
            o_rec_pause <= 1'b0;
            o_rec_stop  <= 1'b0;
            o_play_done <= 1'b0;
            if (load) begin     // hold current word, fetch the next
                rd_addr_r <= rd_addr_r + 1'b1;
                last_r    <= ({1'b0, rd_addr_r} == cnt_last);
            end
            case (mode_r)
                MODE_IDLE: begin
                    if (i_cmd.start_rec) begin
                        o_rec_start <= 1'b1;
                        mode_r      <= MODE_REC;
                    end else if (i_cmd.start_play) begin
                        if (i_rec_count == '0) begin
                            o_play_done <= 1'b1;    // nothing to play
                        end else begin
                            mode_r      <= MODE_PLAY;
                            rd_addr_r   <= '0;
                            wait_cnt_r  <= 2'd2;
                            pause_req_r <= 1'b0;
                        end
                    end
                end
                MODE_REC: begin
                    if (i_cmd.stop) begin
                        o_rec_stop <= 1'b1;
                        mode_r     <= MODE_IDLE;
                    end else if (i_rec_full) begin
                        mode_r <= MODE_IDLE;
                    end else if (i_cmd.pause) begin
                        o_rec_pause <= 1'b1;
                        from_play_r <= 1'b0;
                        mode_r      <= MODE_PAUSE;
                    end
                end
                MODE_PLAY: begin
                    if (wait_cnt_r != 2'd0) begin
                        wait_cnt_r <= wait_cnt_r - 1'b1;
                        if (wait_cnt_r == 2'd1) begin
                            en_r <= 1'b1;   // first word is in the held register
                        end
                    end
                    if (i_cmd.stop) begin
                        en_r       <= 1'b0;
                        wait_cnt_r <= '0;
                        mode_r     <= MODE_IDLE;
                    end else if (i_frame_done && en_r) begin
                        if (last_r) begin
                            o_play_done <= 1'b1;
                            en_r        <= 1'b0;
                            mode_r      <= MODE_IDLE;
                        end else if (pause_req_r || i_cmd.pause) begin
                            en_r        <= 1'b0;
                            pause_req_r <= 1'b0;
                            from_play_r <= 1'b1;
                            mode_r      <= MODE_PAUSE;
                        end
                    end else if (i_cmd.pause) begin
                        pause_req_r <= 1'b1;    // let the frame finish
                    end
                end
                MODE_PAUSE: begin
                    if (i_cmd.stop) begin
                        o_rec_stop <= !from_play_r;
                        mode_r     <= MODE_IDLE;
                    end else if (from_play_r && i_cmd.start_play) begin
                        en_r   <= 1'b1;
                        mode_r <= MODE_PLAY;
                    end else if (!from_play_r && i_cmd.start_rec) begin
                        o_rec_start <= 1'b1;
                        mode_r      <= MODE_REC;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_bclk) begin
        if (load) begin
            held_r <= i_rd_data;
        end
    end

    a_en_only_in_play: assert property (@(posedge i_bclk) disable iff (!i_rst_n)
        o_play_en |-> (mode_r == MODE_PLAY));

endmodule

/* src/sample_ram.sv */
`timescale 1ns/1ps

module sample_ram
    import aud_pkg::*;
#(
    parameter int P_DEPTH = 64,
    localparam int AW = $clog2(P_DEPTH)
) (
    input  logic          i_bclk,
    input  ram_wr_t       i_wr,
    input  logic [AW:0]   i_wr_addr,
    input  logic [AW-1:0] i_rd_addr,
    output sample_t       o_rd_data
);

    sample_t mem [P_DEPTH];

    // write port, address carries the count width
    always_ff @(posedge i_bclk) begin
        if (i_wr.we) begin
            mem[i_wr_addr[AW-1:0]] <= i_wr.data;
        end
    end

    // one cycle read latency
    always_ff @(posedge i_bclk) begin
        o_rd_data <= mem[i_rd_addr];
    end

    // recorder must stop before the count runs past the array
    a_wr_in_range: assert property (@(posedge i_bclk)
        i_wr.we |-> (i_wr_addr < (AW+1)'(P_DEPTH)));

endmodule

/* src/aud_player.sv */
`timescale 1ns/1ps

module aud_player
    import aud_pkg::*;
(
    input  logic    i_bclk,
    input  logic    i_rst_n,
    input  logic    i_daclrck,
    input  logic    i_en,
    input  sample_t i_sample,
    output logic    o_dacdat,
    output logic    o_frame_done
);

    typedef enum logic [1:0] {
        S_WAIT_L,
        S_LEFT,
        S_WAIT_R,
        S_RIGHT
    } play_state_e;

    play_state_e state_r, state_w;
    logic [3:0]  bit_idx_r, bit_idx_w;
    logic        dac_r, dac_w;
    logic        done_r, done_w;
    logic        lrck_q;

    assign o_dacdat     = dac_r;
    assign o_frame_done = done_r;

    always_comb begin
        state_w   = state_r;
        bit_idx_w = bit_idx_r;
        dac_w     = dac_r;
        done_w    = 1'b0;

        case (state_r)
            S_WAIT_L: begin
                // only a fresh falling lrck starts a frame
                if (i_en && lrck_q && !i_daclrck) begin
                    state_w = S_LEFT;
                end
            end
            S_WAIT_R: begin
                if (i_daclrck) begin    // right slot always finishes the frame
                    state_w = S_RIGHT;
                end
            end
            S_LEFT, S_RIGHT: begin
                dac_w     = i_sample[bit_idx_r];    // msb first
                bit_idx_w = bit_idx_r - 1'b1;       // wraps back to 15
                if (bit_idx_r == 4'd0) begin
                    if (state_r == S_LEFT) begin
                        state_w = S_WAIT_R;
                    end else begin
                        state_w = S_WAIT_L;
                        done_w  = 1'b1;
                    end
                end
            end
        endcase
    end

    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r   <= S_WAIT_L;
            bit_idx_r <= 4'hf;
            dac_r     <= 1'b0;
            done_r    <= 1'b0;
            lrck_q    <= 1'b0;
        end else begin
            state_r   <= state_w;
            bit_idx_r <= bit_idx_w;
            dac_r     <= dac_w;
            done_r    <= done_w;
            lrck_q    <= i_daclrck;
        end
    end

    a_frame_done_pulse: assert property (@(posedge i_bclk) disable iff (!i_rst_n)
        o_frame_done |=> !o_frame_done);

endmodule

/* src/aud_recorder.sv */
`timescale 1ns/1ps

module aud_recorder
    import aud_pkg::*;
#(
    parameter int P_DEPTH = 64,
    localparam int AW = $clog2(P_DEPTH)
) (
    input  logic        i_bclk,
    input  logic        i_rst_n,
    input  logic        i_daclrck,
    input  logic        i_adcdat,
    input  logic        i_start,
    input  logic        i_pause,
    input  logic        i_stop,
    output ram_wr_t     o_wr,
    output logic [AW:0] o_wr_addr,
    output logic [AW:0] o_count,
    output logic        o_full
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REC,      // shifting the left slot
        S_WAIT,     // waiting for lrck high
        S_PAUSE
    } rec_state_e;

    rec_state_e  state_r, state_w;
    logic [4:0]  bit_cnt_r, bit_cnt_w;
    logic [AW:0] count_r;
    logic        we_r, we_w;
    logic        shift_en;
    logic        at_depth;
    sample_t     shift_r;

    assign at_depth  = (count_r == (AW+1)'(P_DEPTH));
    assign o_full    = at_depth && (state_r != S_IDLE);
    assign o_wr      = '{we: we_r, data: shift_r};
    assign o_wr_addr = count_r;     // count doubles as next free slot
    assign o_count   = count_r;

    always_comb begin
        state_w   = state_r;
        bit_cnt_w = bit_cnt_r;
        we_w      = 1'b0;
        shift_en  = 1'b0;

        case (state_r)
            S_IDLE: begin
                if (i_start) begin
                    state_w = S_WAIT;
                end
            end
            S_REC: begin
                if (i_stop) begin
                    state_w = S_IDLE;
                end else if (i_pause) begin
                    state_w = S_PAUSE;
                end else if (!i_daclrck) begin  // left slot only
                    shift_en = 1'b1;
                    if (bit_cnt_r == 5'(REC_BITS - 1)) begin
                        we_w      = 1'b1;
                        bit_cnt_w = '0;
                        state_w   = S_WAIT;
                    end else begin
                        bit_cnt_w = bit_cnt_r + 1'b1;
                    end
                end
            end
            S_WAIT: begin
                if (i_stop || at_depth) begin
                    state_w = S_IDLE;
                end else if (i_pause) begin
                    state_w = S_PAUSE;
                end else if (i_daclrck) begin
                    state_w   = S_REC;
                    bit_cnt_w = '0;
                end
            end
            S_PAUSE: begin
                if (i_stop) begin
                    state_w = S_IDLE;
                end else if (i_start) begin
                    state_w = S_WAIT;   // rearm on the next frame
                end
            end
        endcase
    end

    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r   <= S_IDLE;
            bit_cnt_r <= '0;
            we_r      <= 1'b0;
            count_r   <= '0;
        end else begin
            state_r   <= state_w;
            bit_cnt_r <= bit_cnt_w;
            we_r      <= we_w;
            if (state_r == S_IDLE && i_start) begin
                count_r <= '0;              // fresh take
            end else if (we_r) begin
                count_r <= count_r + 1'b1;  // write lands this edge
            end
        end
    end

    // first bit falls off the top after 16 more shifts
    always_ff @(posedge i_bclk) begin
        if (shift_en) begin
            shift_r <= {shift_r[SAMPLE_W-2:0], i_adcdat};
        end
    end

    // stop and pause win over a sample that is just completing
    a_no_wr_when_stopped: assert property (@(posedge i_bclk) disable iff (!i_rst_n)
        (i_stop || i_pause) |=> !o_wr.we);

endmodule

/* src/aud_pkg.sv */
package aud_pkg;

    // audio sample format
    localparam int SAMPLE_W = 16;

    // left slot is sampled for one extra bit, the I2S one-bit delay
    localparam int REC_BITS = SAMPLE_W + 1;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // controller mode, also seen at the top level
    typedef enum logic [1:0] {
        MODE_IDLE  = 2'd0,
        MODE_REC   = 2'd1,
        MODE_PLAY  = 2'd2,
        MODE_PAUSE = 2'd3
    } aud_mode_e;

    // one-cycle command pulses from the host side
    typedef struct packed {
        logic start_rec;
        logic start_play;
        logic pause;
        logic stop;
    } aud_cmd_t;

    // recorder to sample memory
    typedef struct packed {
        logic    we;
        sample_t data;
    } ram_wr_t;

endpackage
